/* source/conv_geometry_pkg.sv */
package conv_geometry_pkg;

	// ----------------------------------------------------------
	// Grid and word sizes
	// ----------------------------------------------------------

	// Pixels, weights, partial sums and results share one width
	localparam int data_width = 8;

	// Side of the input image
	localparam int image_dim = 4;

	// Side of the filter, and so of the PE array
	localparam int kernel_dim = 3;

	// Side of the valid output map
	localparam int out_dim = image_dim - kernel_dim + 1;

	// ----------------------------------------------------------
	// Data word
	// ----------------------------------------------------------

	// Unsigned, all arithmetic wraps at data_width
	typedef logic [data_width-1:0] pixel_t;

endpackage

/* source/conv_schedule_pkg.sv */
package conv_schedule_pkg;

	// ----------------------------------------------------------
	// Cycle counter
	// ----------------------------------------------------------

	localparam int count_width = 8;

	typedef logic [count_width-1:0] count_t;

	// ----------------------------------------------------------
	// Schedule, in counter values
	// ----------------------------------------------------------

	// Drain window after pass one
	localparam count_t pass_one_mode_first = 8'd16;
	localparam count_t pass_one_mode_last = 8'd20;

	// Drain window after pass two
	localparam count_t pass_two_mode_first = 8'd28;
	localparam count_t pass_two_mode_last = 8'd31;

	// Wipes the array once the pass-one sums have left it
	localparam count_t clear_cycle = 8'd20;

	// From here on the feeder serves the pass-two streams
	localparam count_t pass_select_cycle = 8'd16;

	// Diagonal taps hold o00, o01 and o10
	localparam count_t capture_one_cycle = 8'd19;

	// Diagonal taps hold the three parts of o11
	localparam count_t capture_two_cycle = 8'd31;

	// Counter stops here, done follows one cycle later
	localparam count_t run_length = 8'd32;

endpackage

/* source/conv_sequencer.sv */
`timescale 1ns/10ps

module conv_sequencer (
	input  logic                      clk_in,
	input  logic                      arst_n,
	output conv_schedule_pkg::count_t count,
	output logic                      mode,
	output logic                      clear,
	output logic                      capture_one,
	output logic                      capture_two,
	output logic                      done
);

	logic mode_next;
	logic at_end;

	// Either drain window
	assign mode_next =
		(count >= conv_schedule_pkg::pass_one_mode_first &&
		 count <= conv_schedule_pkg::pass_one_mode_last) ||
		(count >= conv_schedule_pkg::pass_two_mode_first &&
		 count <= conv_schedule_pkg::pass_two_mode_last);

	assign at_end = (count == conv_schedule_pkg::run_length);

	// ----------------------------------------------------------
	// Counter and registered strobes
	// ----------------------------------------------------------

	// Every decode goes through a flop so the array sees clean levels
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			count       <= '0;
			mode        <= 1'b0;
			clear       <= 1'b0;
			capture_one <= 1'b0;
			capture_two <= 1'b0;
			done        <= 1'b0;
		end else if (!done) begin
			if (!at_end) begin
				count <= count + conv_schedule_pkg::count_t'(1);
			end
			mode        <= mode_next;
			clear       <= (count == conv_schedule_pkg::clear_cycle);
			capture_one <= (count == conv_schedule_pkg::capture_one_cycle);
			capture_two <= (count == conv_schedule_pkg::capture_two_cycle);
			// Sticky once set, since the whole block stops with it
			done        <= at_end;
		end
	end

endmodule

/* source/operand_feeder.sv */
`timescale 1ns/10ps

module operand_feeder (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  logic                      done,
	input  conv_schedule_pkg::count_t count,
	input  conv_geometry_pkg::pixel_t image
		[conv_geometry_pkg::image_dim][conv_geometry_pkg::image_dim],
	input  conv_geometry_pkg::pixel_t filter
		[conv_geometry_pkg::kernel_dim][conv_geometry_pkg::kernel_dim],
	output conv_geometry_pkg::pixel_t row_operand [conv_geometry_pkg::kernel_dim],
	output conv_geometry_pkg::pixel_t col_operand [conv_geometry_pkg::kernel_dim]
);

	localparam int kd = conv_geometry_pkg::kernel_dim;
	localparam int od = conv_geometry_pkg::out_dim;

	conv_geometry_pkg::pixel_t row_next [kd];
	conv_geometry_pkg::pixel_t col_next [kd];

	// ----------------------------------------------------------
	// Stream selection
	// ----------------------------------------------------------

	// Pixels and weights both run backwards through the window
	// so each pair still meets unflipped in the diagonal PEs.
	// Slots outside a stream feed zero.
	always_comb begin
		row_next = '{default: '0};
		col_next = '{default: '0};
		if (count < conv_schedule_pkg::pass_select_cycle) begin
			// Pass one: rows carry the o00, o01 and o10 windows
			for (int wy = 0; wy < kd; wy++) begin
				for (int wx = 0; wx < kd; wx++) begin
					if (count == conv_schedule_pkg::count_t'(kd * kd - 1 - (wy * kd + wx))) begin
						for (int r = 0; r < kd; r++) begin
							row_next[r] = image[r / od + wy][r % od + wx];
						end
						for (int c = 0; c < kd; c++) begin
							col_next[c] = filter[wy][wx];
						end
					end
				end
			end
		end else begin
			// Pass two: row r of the o11 window meets filter row r,
			// starting right after the clear
			for (int x = 0; x < kd; x++) begin
				if (count == conv_schedule_pkg::clear_cycle +
						conv_schedule_pkg::count_t'(kd - x)) begin
					for (int r = 0; r < kd; r++) begin
						row_next[r] = image[r + 1][1 + x];
					end
					for (int c = 0; c < kd; c++) begin
						col_next[c] = filter[c][x];
					end
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Operand registers
	// ----------------------------------------------------------

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			row_operand <= '{default: '0};
			col_operand <= '{default: '0};
		end else if (!done) begin
			row_operand <= row_next;
			col_operand <= col_next;
		end
	end

endmodule

/* source/processing_element.sv */
`timescale 1ns/10ps

module processing_element (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  logic                      done,
	input  logic                      mode,
	input  logic                      clear,
	input  conv_geometry_pkg::pixel_t a_in,
	input  conv_geometry_pkg::pixel_t b_in,
	input  conv_geometry_pkg::pixel_t c_in,
	output conv_geometry_pkg::pixel_t a_out,
	output conv_geometry_pkg::pixel_t b_out,
	output conv_geometry_pkg::pixel_t c_out
);

	conv_geometry_pkg::pixel_t addend;

	// Mode low keeps the sum local, mode high passes sums down the column
	assign addend = mode ? c_in : c_out;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			a_out <= '0;
			b_out <= '0;
			c_out <= '0;
		end else if (!done) begin
			if (clear) begin
				a_out <= '0;
				b_out <= '0;
				c_out <= '0;
			end else begin
				a_out <= a_in;
				b_out <= b_in;
				c_out <= addend + a_in * b_in;
			end
		end
	end

endmodule

/* source/pe_array.sv */
`timescale 1ns/10ps

module pe_array (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  logic                      done,
	input  logic                      mode,
	input  logic                      clear,
	input  conv_geometry_pkg::pixel_t row_operand [conv_geometry_pkg::kernel_dim],
	input  conv_geometry_pkg::pixel_t col_operand [conv_geometry_pkg::kernel_dim],
	output conv_geometry_pkg::pixel_t column_sum [conv_geometry_pkg::kernel_dim]
);

	localparam int kd = conv_geometry_pkg::kernel_dim;

	// Pixels move right, weights and sums move down
	conv_geometry_pkg::pixel_t a_w [kd][kd+1];
	conv_geometry_pkg::pixel_t b_w [kd+1][kd];
	conv_geometry_pkg::pixel_t c_w [kd+1][kd];

	for (genvar r = 0; r < kd; r++) begin : g_row_edge
		assign a_w[r][0] = row_operand[r];
	end

	for (genvar c = 0; c < kd; c++) begin : g_col_edge
		assign b_w[0][c]    = col_operand[c];
		assign c_w[0][c]    = '0;
		assign column_sum[c] = c_w[kd][c];
	end

	for (genvar r = 0; r < kd; r++) begin : g_row
		for (genvar c = 0; c < kd; c++) begin : g_col
			processing_element i_pe (
				.clk_in (clk_in),
				.arst_n (arst_n),
				.done   (done),
				.mode   (mode),
				.clear  (clear),
				.a_in   (a_w[r][c]),
				.b_in   (b_w[r][c]),
				.c_in   (c_w[r][c]),
				.a_out  (a_w[r][c+1]),
				.b_out  (b_w[r+1][c]),
				.c_out  (c_w[r+1][c])
			);
		end
	end

endmodule

/* source/result_capture.sv */
`timescale 1ns/10ps

module result_capture (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  logic                      done,
	input  logic                      capture_one,
	input  logic                      capture_two,
	input  conv_geometry_pkg::pixel_t column_sum [conv_geometry_pkg::kernel_dim],
	output conv_geometry_pkg::pixel_t o00,
	output conv_geometry_pkg::pixel_t o01,
	output conv_geometry_pkg::pixel_t o10,
	output conv_geometry_pkg::pixel_t o11
);

	localparam int kd = conv_geometry_pkg::kernel_dim;

	// shift_q[c][d] is column c delayed by d+1 cycles
	conv_geometry_pkg::pixel_t shift_q [kd][kd];
	conv_geometry_pkg::pixel_t part_q [kd];

	// Tap depth per column makes up for the drain distance of PE(c,c)
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			shift_q <= '{default: '{default: '0}};
			part_q  <= '{default: '0};
			o00     <= '0;
			o01     <= '0;
			o10     <= '0;
		end else if (!done) begin
			for (int c = 0; c < kd; c++) begin
				shift_q[c][0] <= column_sum[c];
				for (int d = 1; d < kd; d++) begin
					shift_q[c][d] <= shift_q[c][d-1];
				end
			end
			if (capture_one) begin
				o00 <= shift_q[0][0];
				o01 <= shift_q[1][1];
				o10 <= shift_q[2][2];
			end
			if (capture_two) begin
				for (int c = 0; c < kd; c++) begin
					part_q[c] <= shift_q[c][c];
				end
			end
		end
	end

	// Pass two leaves one filter row per diagonal PE
	assign o11 = part_q[0] + part_q[1] + part_q[2];

endmodule

/* source/systolic_conv_top.sv */
`timescale 1ns/10ps

module systolic_conv_top (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  conv_geometry_pkg::pixel_t image
		[conv_geometry_pkg::image_dim][conv_geometry_pkg::image_dim],
	input  conv_geometry_pkg::pixel_t filter
		[conv_geometry_pkg::kernel_dim][conv_geometry_pkg::kernel_dim],
	output conv_geometry_pkg::pixel_t o00,
	output conv_geometry_pkg::pixel_t o01,
	output conv_geometry_pkg::pixel_t o10,
	output conv_geometry_pkg::pixel_t o11,
	output logic                      done
);

	conv_schedule_pkg::count_t count;
	logic                      mode;
	logic                      clear;
	logic                      capture_one;
	logic                      capture_two;
	conv_geometry_pkg::pixel_t row_operand [conv_geometry_pkg::kernel_dim];
	conv_geometry_pkg::pixel_t col_operand [conv_geometry_pkg::kernel_dim];
	conv_geometry_pkg::pixel_t column_sum [conv_geometry_pkg::kernel_dim];

	conv_sequencer i_sequencer (
		.clk_in      (clk_in),
		.arst_n      (arst_n),
		.count       (count),
		.mode        (mode),
		.clear       (clear),
		.capture_one (capture_one),
		.capture_two (capture_two),
		.done        (done)
	);

	operand_feeder i_feeder (
		.clk_in      (clk_in),
		.arst_n      (arst_n),
		.done        (done),
		.count       (count),
		.image       (image),
		.filter      (filter),
		.row_operand (row_operand),
		.col_operand (col_operand)
	);

	pe_array i_array (
		.clk_in      (clk_in),
		.arst_n      (arst_n),
		.done        (done),
		.mode        (mode),
		.clear       (clear),
		.row_operand (row_operand),
		.col_operand (col_operand),
		.column_sum  (column_sum)
	);

	result_capture i_capture (
		.clk_in      (clk_in),
		.arst_n      (arst_n),
		.done        (done),
		.capture_one (capture_one),
		.capture_two (capture_two),
		.column_sum  (column_sum),
		.o00         (o00),
		.o01         (o01),
		.o10         (o10),
		.o11         (o11)
	);

endmodule

/* verification/tb_conv_vectors.svh */
// One column per array below, one row per test:
// name, image i00..i33 in raster order with i00 in the top byte,
// filter w00..w22 in raster order, expected {o00, o01, o10, o11}

localparam int num_vectors = 4;

string vec_name [num_vectors] = '{
	"small_distinct",
	"identity_center",
	"wrap_o11",
	"wrap_products"
};

localparam logic [127:0] vec_image [num_vectors] = '{
	128'h01020304_05060708_090a0b0c_0d0e0f10,
	128'ha0a1a2a3_b0b1b2b3_c0c1c2c3_d0d1d2d3,
	128'h01010101_01010101_01010101_010101ff,
	128'hffffffff_ffffffff_ffffffff_ffffffff
};

localparam logic [71:0] vec_filter [num_vectors] = '{
	72'h010201_000100_020001,
	72'h000000_000100_000000,
	72'h010101_010101_010103,
	72'hffffff_ffffff_ffffff
};

// Window sums by hand, mod 256
localparam logic [31:0] vec_expect [num_vectors] = '{
	32'h2b_33_4b_53,
	32'hb1_b2_c1_c2,
	32'h0b_0b_0b_05,
	32'h09_09_09_09
};

/* verification/tb_systolic_conv.sv */
`timescale 1ns/10ps

module tb_systolic_conv;

	localparam int reset_cycles = 16;
	localparam int hold_cycles = 20;
	localparam int margin_cycles = 40;
	localparam int random_tests = 6;
	localparam int run_cycles = int'(conv_schedule_pkg::run_length);

	`include "tb_conv_vectors.svh"

	// Whole run, with slack for reset, drain and the hold check
	localparam int timeout_cycles =
		(num_vectors + random_tests) * (run_cycles + reset_cycles + margin_cycles);

	logic                      clk_in;
	logic                      arst_n;
	conv_geometry_pkg::pixel_t image
		[conv_geometry_pkg::image_dim][conv_geometry_pkg::image_dim];
	conv_geometry_pkg::pixel_t filter
		[conv_geometry_pkg::kernel_dim][conv_geometry_pkg::kernel_dim];
	conv_geometry_pkg::pixel_t o00;
	conv_geometry_pkg::pixel_t o01;
	conv_geometry_pkg::pixel_t o10;
	conv_geometry_pkg::pixel_t o11;
	logic                      done;
	int                        cycle_count = 0;
	int                        value_errors = 0;
	int                        done_errors = 0;
	integer                    seed;

	systolic_conv_top i_dut (
		.clk_in (clk_in),
		.arst_n (arst_n),
		.image  (image),
		.filter (filter),
		.o00    (o00),
		.o01    (o01),
		.o10    (o10),
		.o11    (o11),
		.done   (done)
	);

	// 8 ns period
	always #4 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Compare tasks and reference model
	// ----------------------------------------------------------

	task automatic check_pixel(input string test_name, input string label,
			input conv_geometry_pkg::pixel_t expected, input conv_geometry_pkg::pixel_t actual);
		if (actual !== expected) begin
			$display("** Error %s %s: expected 0x%02h, actual 0x%02h",
				test_name, label, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_done(input string test_name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s done: expected %b, actual %b", test_name, expected, actual);
			done_errors++;
		end
	endtask

	task automatic check_outputs(input string test_name, input logic [31:0] expected);
		check_pixel(test_name, "o00", expected[31:24], o00);
		check_pixel(test_name, "o01", expected[23:16], o01);
		check_pixel(test_name, "o10", expected[15:8], o10);
		check_pixel(test_name, "o11", expected[7:0], o11);
	endtask

	// Unflipped filter, sum truncated to 8 bits
	function automatic conv_geometry_pkg::pixel_t window_sum(input logic [127:0] img,
			input logic [71:0] flt, input int oy, input int ox);
		conv_geometry_pkg::pixel_t acc;
		acc = '0;
		for (int ky = 0; ky < 3; ky++) begin
			for (int kx = 0; kx < 3; kx++) begin
				acc = acc + img[127 - 8 * (4 * (oy + ky) + ox + kx) -: 8] *
					flt[71 - 8 * (3 * ky + kx) -: 8];
			end
		end
		return acc;
	endfunction

	task automatic drive_inputs(input logic [127:0] img, input logic [71:0] flt);
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				image[y][x] = img[127 - 8 * (4 * y + x) -: 8];
			end
		end
		for (int y = 0; y < 3; y++) begin
			for (int x = 0; x < 3; x++) begin
				filter[y][x] = flt[71 - 8 * (3 * y + x) -: 8];
			end
		end
	endtask

	// ----------------------------------------------------------
	// One test from reset to the hold check
	// ----------------------------------------------------------

	task automatic run_test(input string name, input logic [127:0] img,
			input logic [71:0] flt, input logic [31:0] expected);
		int waited;
		@(negedge clk_in);
		arst_n = 1'b0;
		drive_inputs(img, flt);
		repeat (reset_cycles) @(negedge clk_in);
		check_done(name, 1'b0, done);
		arst_n = 1'b1;
		@(negedge clk_in);
		check_done(name, 1'b0, done);
		waited = 0;
		while (!done && waited < run_cycles + margin_cycles) begin
			@(negedge clk_in);
			waited++;
		end
		if (!done) begin
			$display("Test %s: done did not rise within %0d cycles", name, waited);
			done_errors++;
		end
		check_outputs(name, expected);
		// Results are frozen, new inputs must not reach them
		drive_inputs(~img, ~flt);
		repeat (hold_cycles) begin
			@(negedge clk_in);
			check_done(name, 1'b1, done);
			check_outputs(name, expected);
		end
	endtask

	initial begin
		logic [127:0] img;
		logic [71:0]  flt;
		logic [31:0]  expected;
		clk_in = 1'b0;
		arst_n = 1'b0;
		seed = 32'h3489_1b1c;
		drive_inputs('0, '0);
		for (int i = 0; i < num_vectors; i++) begin
			run_test(vec_name[i], vec_image[i], vec_filter[i], vec_expect[i]);
		end
		for (int t = 0; t < random_tests; t++) begin
			for (int k = 0; k < 16; k++) begin
				img[8 * k +: 8] = $random(seed);
			end
			for (int k = 0; k < 9; k++) begin
				flt[8 * k +: 8] = $random(seed);
			end
			expected = {window_sum(img, flt, 0, 0), window_sum(img, flt, 0, 1),
				window_sum(img, flt, 1, 0), window_sum(img, flt, 1, 1)};
			run_test($sformatf("random_%0d", t), img, flt, expected);
		end
		$display("Errors: %0d value, %0d done", value_errors, done_errors);
		if (value_errors + done_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verification
source/conv_geometry_pkg.sv
source/conv_schedule_pkg.sv
source/conv_sequencer.sv
source/operand_feeder.sv
source/processing_element.sv
source/pe_array.sv
source/result_capture.sv
source/systolic_conv_top.sv
verification/tb_systolic_conv.sv

/* Bender.yml */
package:
  name: systolic_conv

sources:
  - source/conv_geometry_pkg.sv
  - source/conv_schedule_pkg.sv
  - source/conv_sequencer.sv
  - source/operand_feeder.sv
  - source/processing_element.sv
  - source/pe_array.sv
  - source/result_capture.sv
  - source/systolic_conv_top.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_systolic_conv.sv
